// File: alu.sv
// 16-bit ALU with arithmetic, logic, shift, rotate, compare, reverse and byte load ops
`include "wisc_defs.svh"

module alu (
    input  wiscPkg::aluOpT aluOp,
    input  wiscPkg::wordT  a,           // Rs
    input  wiscPkg::wordT  b,           // Rt or immediate
    output wiscPkg::wordT  result
);

    logic [`WORD_W:0] sum;              // Carry in the top bit
    logic [3:0]       shAmt;
    wiscPkg::wordT    rev;

    assign sum   = {1'b0, a} + {1'b0, b};
    assign shAmt = b[3:0];

    always_comb begin
        for (int i = 0; i < `WORD_W; i++) begin
            rev[i] = a[`WORD_W-1-i];
        end
    end

    always_comb begin
        case (aluOp)
            wiscPkg::aluAdd:   result = sum[`WORD_W-1:0];
            wiscPkg::aluSub:   result = b - a;
            wiscPkg::aluXor:   result = a ^ b;
            wiscPkg::aluAndn:  result = a & ~b;
            wiscPkg::aluRol:   result = (a << shAmt) | (a >> (`WORD_W - shAmt));  // Zero amount ok
            wiscPkg::aluSll:   result = a << shAmt;
            wiscPkg::aluRor:   result = (a >> shAmt) | (a << (`WORD_W - shAmt));
            wiscPkg::aluSrl:   result = a >> shAmt;
            wiscPkg::aluSeq:   result = {15'd0, a == b};
            wiscPkg::aluSlt:   result = {15'd0, $signed(a) < $signed(b)};
            wiscPkg::aluSle:   result = {15'd0, $signed(a) <= $signed(b)};
            wiscPkg::aluSco:   result = {15'd0, sum[`WORD_W]};
            wiscPkg::aluBtr:   result = rev;
            wiscPkg::aluPassB: result = b;
            wiscPkg::aluSlbi:  result = (a << 8) | b;   // b is zero-extended byte
            default:           result = '0;
        endcase
    end

endmodule

// File: control.sv
// Main decoder from instruction word and Rs flags to the control struct
`include "wisc_defs.svh"

module control (
    input  wiscPkg::wordT instr,
    input  logic          rsZero,   // Rs == 0
    input  logic          rsNeg,    // Rs sign bit
    output wiscPkg::ctrlT ctrl
);

    wiscPkg::opcodeT opc;

    assign opc = instr[`OPC_HI:`OPC_LO];

    always_comb begin
        ctrl = '0;                              // NOP unless decoded below
        ctrl.immSel  = wiscPkg::immZero5;
        ctrl.linkSel = wiscPkg::linkRs;
        ctrl.aluOp   = wiscPkg::aluAdd;
        casez (opc)
            `HALT_OPC: ctrl.halt = 1'b1;
            5'b00100, 5'b00110: begin           // J, JAL
                ctrl.pcSel    = 1'b1;
                ctrl.immSel   = wiscPkg::immSign11;
                ctrl.regWrite = opc[1];         // JAL links
                ctrl.pc2Reg   = opc[1];
                ctrl.linkSel  = wiscPkg::linkR7;
            end
            5'b00101, 5'b00111: begin           // JR, JALR
                ctrl.pcSel    = 1'b1;
                ctrl.jumpReg  = 1'b1;           // Rs + imm
                ctrl.immSel   = wiscPkg::immSign8;
                ctrl.regWrite = opc[1];
                ctrl.pc2Reg   = opc[1];
                ctrl.linkSel  = wiscPkg::linkR7;
            end
            5'b010??: begin                     // ADDI, SUBI, XORI, ANDNI
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.immSel   = opc[1] ? wiscPkg::immZero5 : wiscPkg::immSign5;  // Logic ops zero
                ctrl.linkSel  = wiscPkg::linkRdI;
                ctrl.aluOp    = wiscPkg::aluOpT'({2'b00, opc[1:0]});
            end
            5'b101??: begin                     // ROLI, SLLI, RORI, SRLI
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.linkSel  = wiscPkg::linkRdI;
                ctrl.aluOp    = wiscPkg::aluOpT'({2'b01, opc[1:0]});
            end
            5'b10000, 5'b10001, 5'b10011: begin // ST, LD, STU
                ctrl.immExt   = 1'b1;           // Address is Rs + imm
                ctrl.immSel   = wiscPkg::immSign5;
                ctrl.memRead  = (opc == 5'b10001);
                ctrl.val2Reg  = (opc == 5'b10001);
                ctrl.memWrite = (opc != 5'b10001);
                ctrl.regWrite = (opc != 5'b10000);
                ctrl.linkSel  = opc[1] ? wiscPkg::linkRs : wiscPkg::linkRdI;  // STU updates Rs
            end
            5'b10010: begin                     // SLBI
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.immSel   = wiscPkg::immZero8;
                ctrl.aluOp    = wiscPkg::aluSlbi;
            end
            5'b11000: begin                     // LBI
                ctrl.regWrite = 1'b1;
                ctrl.immExt   = 1'b1;
                ctrl.immSel   = wiscPkg::immSign8;
                ctrl.aluOp    = wiscPkg::aluPassB;
            end
            5'b11001: begin                     // BTR
                ctrl.regWrite = 1'b1;
                ctrl.linkSel  = wiscPkg::linkRdR;
                ctrl.aluOp    = wiscPkg::aluBtr;
            end
            5'b1101?: begin                     // Shift group and add group, func in 1:0
                ctrl.regWrite = 1'b1;
                ctrl.linkSel  = wiscPkg::linkRdR;
                ctrl.aluOp    = wiscPkg::aluOpT'({1'b0, ~opc[0], instr[1:0]});
            end
            5'b111??: begin                     // SEQ, SLT, SLE, SCO
                ctrl.regWrite = 1'b1;
                ctrl.linkSel  = wiscPkg::linkRdR;
                ctrl.aluOp    = wiscPkg::aluOpT'({2'b10, opc[1:0]});
            end
            5'b011??: begin                     // BEQZ, BNEZ, BLTZ, BGEZ
                ctrl.immSel = wiscPkg::immSign8;
                case (opc[1:0])
                    2'b00:   ctrl.pcSel = rsZero;
                    2'b01:   ctrl.pcSel = ~rsZero;
                    2'b10:   ctrl.pcSel = rsNeg;
                    default: ctrl.pcSel = ~rsNeg;
                endcase
            end
            default: ;                          // NOP, siic, RTI, unused
        endcase
    end

endmodule

// File: filelist.f
+incdir+.
wiscPkg.sv
control.sv
regFile.sv
alu.sv
immExtend.sv
pcUnit.sv
wiscCore.sv
tb_wiscCore.sv

// File: immExtend.sv
// Immediate field select with zero or sign extension to a full word
`include "wisc_defs.svh"

module immExtend (
    input  wiscPkg::wordT   instr,
    input  wiscPkg::immSelT immSel,
    output wiscPkg::wordT   imm
);

    always_comb begin
        case (immSel)
            wiscPkg::immZero5:
                imm = {{(`WORD_W-`IMM5_W){1'b0}}, instr[`IMM5_W-1:0]};
            wiscPkg::immSign5:
                imm = {{(`WORD_W-`IMM5_W){instr[`IMM5_W-1]}}, instr[`IMM5_W-1:0]};
            wiscPkg::immZero8:
                imm = {{(`WORD_W-`IMM8_W){1'b0}}, instr[`IMM8_W-1:0]};      // SLBI
            wiscPkg::immSign8:
                imm = {{(`WORD_W-`IMM8_W){instr[`IMM8_W-1]}}, instr[`IMM8_W-1:0]};
            wiscPkg::immSign11:
                imm = {{(`WORD_W-`IMM11_W){instr[`IMM11_W-1]}}, instr[`IMM11_W-1:0]};  // J, JAL
            default:
                imm = '0;
        endcase
    end

endmodule

// File: pcUnit.sv
// Program counter, next-PC selection and the halted flag
module pcUnit (
    input  logic          clk,
    input  logic          rstN,
    input  wiscPkg::ctrlT ctrl,
    input  wiscPkg::wordT rsData,
    input  wiscPkg::wordT imm,
    output wiscPkg::addrT pc,
    output wiscPkg::addrT pcPlus2,
    output logic          halted
);

    wiscPkg::addrT base;
    wiscPkg::addrT nextPc;

    assign pcPlus2 = pc + 16'd2;
    assign base    = ctrl.jumpReg ? rsData : pcPlus2;    // JR/JALR use Rs
    assign nextPc  = ctrl.pcSel ? base + imm : pcPlus2;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (ctrl.halt) begin
                halted <= 1'b1;                 // Sticky until reset
            end
            if (!halted && !ctrl.halt) begin
                pc <= nextPc;                   // Stays on the HALT word
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
        else $error("pcUnit: odd PC %h", pc);

endmodule

// File: regFile.sv
// Eight-entry register file, two asynchronous reads and one clocked write
`include "wisc_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  wiscPkg::regAddrT rdAddr1,
    input  wiscPkg::regAddrT rdAddr2,
    output wiscPkg::wordT    rdData1,
    output wiscPkg::wordT    rdData2,
    input  logic             wrEn,
    input  wiscPkg::regAddrT wrAddr,
    input  wiscPkg::wordT    wrData
);

    wiscPkg::wordT regs [`REG_CNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;                  // All registers start at zero
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdData1 = regs[rdAddr1];             // Old value during a same-cycle write
    assign rdData2 = regs[rdAddr2];

    // Destination comes from the instruction, so an X here means a bad fetch
    assert property (@(posedge clk) disable iff (!rstN) wrEn |-> !$isunknown(wrAddr))
        else $error("regFile: write enable with unknown address");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the wiscCore testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_wiscCore -Mdir obj_dir
./obj_dir/Vtb_wiscCore > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

// File: tb_wiscCore.sv
// Testbench for wiscCore with memory models, ISA reference model, store compare and timeout
`include "wisc_defs.svh"

module tb_wiscCore;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk, rstN, dmemWe, dmemRe, halted, errFlag;
    wiscPkg::addrT imemAddr, dmemAddr, mPc;
    wiscPkg::wordT imemData, dmemWdata, dmemRdata;
    wiscPkg::wordT firstWord;
    wiscPkg::wordT imem [256];
    wiscPkg::wordT dmem [65536];
    wiscPkg::wordT mMem [65536];               // Model copy of data memory
    wiscPkg::wordT mReg [`REG_CNT];
    wiscPkg::addrT expAddr[$];
    wiscPkg::wordT expData[$];
    int seed = 32'h7439_146c;
    int ptr, steps, limit, passCnt, failCnt, stores, loads, mLoads;
    int cycles = 0;
    int t;

    wiscCore uut (.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRe(dmemRe),
        .dmemRdata(dmemRdata), .halted(halted));

    assign imemData  = imem[imemAddr[8:1]];    // Combinational fetch
    assign dmemRdata = dmem[dmemAddr];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int pickReg();
        return 1 + rnd(6);                      // R0 stays the store pointer
    endfunction

    function automatic wiscPkg::wordT rotl(wiscPkg::wordT x, logic [3:0] n);
        return (x << n) | (x >> (5'd16 - {1'b0, n}));
    endfunction

    function automatic wiscPkg::wordT rotr(wiscPkg::wordT x, logic [3:0] n);
        return (x >> n) | (x << (5'd16 - {1'b0, n}));
    endfunction

    function automatic void storeWord(wiscPkg::addrT ea, wiscPkg::wordT d);
        mMem[ea] = d;
        expAddr.push_back(ea);
        expData.push_back(d);
    endfunction

    // One ISA step on the model state, returns 1 on HALT
    function automatic logic isaStep();
        wiscPkg::wordT i, a, b, s5, z5, s8, pc2, nxt, ea;
        logic [16:0] sum;
        i   = imem[mPc[8:1]];
        a   = mReg[i[10:8]];
        b   = mReg[i[7:5]];
        s5  = {{11{i[4]}}, i[4:0]};
        z5  = {11'd0, i[4:0]};
        s8  = {{8{i[7]}}, i[7:0]};
        pc2 = mPc + 16'd2;
        nxt = pc2;
        ea  = a + s5;
        sum = {1'b0, a} + {1'b0, b};
        isaStep = (i[15:11] == `HALT_OPC);
        case (i[15:11])
            5'b00000: nxt = mPc;                // PC parks on HALT
            5'b00100: nxt = pc2 + {{5{i[10]}}, i[10:0]};
            5'b00110: begin
                nxt = pc2 + {{5{i[10]}}, i[10:0]};
                mReg[7] = pc2;
            end
            5'b00101: nxt = a + s8;
            5'b00111: begin
                nxt = a + s8;                   // Rs read before the link write
                mReg[7] = pc2;
            end
            5'b01000: mReg[i[7:5]] = a + s5;
            5'b01001: mReg[i[7:5]] = s5 - a;
            5'b01010: mReg[i[7:5]] = a ^ z5;
            5'b01011: mReg[i[7:5]] = a & ~z5;
            5'b10100: mReg[i[7:5]] = rotl(a, i[3:0]);
            5'b10101: mReg[i[7:5]] = a << i[3:0];
            5'b10110: mReg[i[7:5]] = rotr(a, i[3:0]);
            5'b10111: mReg[i[7:5]] = a >> i[3:0];
            5'b10000: storeWord(ea, b);
            5'b10001: begin
                mReg[i[7:5]] = mMem[ea];
                mLoads++;
            end
            5'b10011: begin
                storeWord(ea, b);
                mReg[i[10:8]] = ea;
            end
            5'b10010: mReg[i[10:8]] = (a << 8) | {8'd0, i[7:0]};
            5'b11000: mReg[i[10:8]] = s8;
            5'b11001: mReg[i[4:2]] = {<<{a}};  // Bit reverse
            5'b11010: case (i[1:0])
                2'd0: mReg[i[4:2]] = rotl(a, b[3:0]);
                2'd1: mReg[i[4:2]] = a << b[3:0];
                2'd2: mReg[i[4:2]] = rotr(a, b[3:0]);
                default: mReg[i[4:2]] = a >> b[3:0];
            endcase
            5'b11011: case (i[1:0])
                2'd0: mReg[i[4:2]] = sum[15:0];
                2'd1: mReg[i[4:2]] = b - a;
                2'd2: mReg[i[4:2]] = a ^ b;
                default: mReg[i[4:2]] = a & ~b;
            endcase
            5'b11100: mReg[i[4:2]] = {15'd0, a == b};
            5'b11101: mReg[i[4:2]] = {15'd0, $signed(a) < $signed(b)};
            5'b11110: mReg[i[4:2]] = {15'd0, $signed(a) <= $signed(b)};
            5'b11111: mReg[i[4:2]] = {15'd0, sum[16]};
            5'b01100: if (a == 16'd0) nxt = pc2 + s8;
            5'b01101: if (a != 16'd0) nxt = pc2 + s8;
            5'b01110: if (a[15]) nxt = pc2 + s8;
            5'b01111: if (!a[15]) nxt = pc2 + s8;
            default: ;                          // NOP
        endcase
        mPc = nxt;
    endfunction

    function automatic wiscPkg::wordT i1(logic [4:0] op, int rs, int rd, logic [4:0] imm);
        return {op, 3'(rs), 3'(rd), imm};
    endfunction

    function automatic wiscPkg::wordT i2(logic [4:0] op, int rs, logic [7:0] imm);
        return {op, 3'(rs), imm};
    endfunction

    task automatic emit(wiscPkg::wordT w);
        imem[ptr] = w;
        ptr++;
    endtask

    task automatic stu(int r);
        emit(i1(5'b10011, 0, r, 5'd2));         // Store r at R0+2, bump R0
    endtask

    task automatic checkAddr(string name, wiscPkg::addrT exp, wiscPkg::addrT act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errFlag = 1'b1;
        end
    endtask

    task automatic checkWord(string name, wiscPkg::wordT exp, wiscPkg::wordT act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            errFlag = 1'b1;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            errFlag = 1'b1;
        end
    endtask

    task automatic endTest(string name);
        if (errFlag) failCnt++;
        else passCnt++;
        $display("%s: %s", name, errFlag ? "mismatch" : "ok");
        errFlag = 1'b0;
    endtask

    // Data memory write and the store compare, both at the edge where the write lands
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (dmemRe) loads++;
        if (dmemWe) begin
            dmem[dmemAddr] <= dmemWdata;
            stores++;
            if (expAddr.size() == 0) begin
                $display("Store to %h after the model's last store", dmemAddr);
                errFlag = 1'b1;
            end else begin
                checkAddr("store addr", expAddr.pop_front(), dmemAddr);
                checkWord("store data", expData.pop_front(), dmemWdata);
            end
            endTest($sformatf("store %0d", stores));
        end
    end

    initial begin
        rstN = 1'b0;
        errFlag = 1'b0;
        for (int k = 0; k < 65536; k++) begin
            dmem[k] = 16'(k) ^ 16'h5a3c;        // Address-dependent fill
            mMem[k] = dmem[k];
        end
        for (int k = 0; k < 256; k++) imem[k] = {5'b00001, 11'(k)};   // NOP fill
        ptr = 0;
        emit(i2(5'b11000, 0, 8'h40));           // Store pointer
        for (int r = 1; r < 7; r++) emit(i2(5'b11000, r, 8'(rnd(256))));
        emit(i2(5'b10010, 2, 8'(rnd(256))));
        emit(i2(5'b10010, 5, 8'(rnd(256))));
        for (int k = 0; k < 8; k++) begin      // Immediate ALU and shift ops
            t = pickReg();
            emit(i1(k < 4 ? 5'(8 + k) : 5'(20 + k - 4), pickReg(), t, 5'(rnd(32))));
            stu(t);
        end
        for (int k = 0; k < 13; k++) begin     // Shifts, add group, compares, BTR
            t = pickReg();
            emit({k < 4 ? 5'd26 : k < 8 ? 5'd27 : k < 12 ? 5'(28 + k - 8) : 5'd25,
                3'(pickReg()), 3'(pickReg()), 3'(t), 2'(k)});
            stu(t);
        end
        emit(i1(5'b10001, 0, 3, 5'd0));         // LD the last stored word
        stu(3);
        emit(i1(5'b10000, 0, 0, 5'd2));         // ST R0 proves the STU updates
        emit(i1(5'b01000, 0, 0, 5'd4));
        for (int v = 0; v < 3; v++) begin      // Zero, positive, negative
            emit(i2(5'b11000, 1, v == 0 ? 8'h00 : v == 1 ? 8'h05 : 8'hfd));
            for (int b = 0; b < 4; b++) begin
                emit(i2(5'b11000, 4, 8'(16 + 4 * v + b)));
                emit(i2(5'(12 + b), 1, 8'd2));
                emit(i2(5'b11000, 4, 8'(96 + 4 * v + b)));
                stu(4);
            end
        end
        emit(i2(5'b11000, 4, 8'h31));
        emit({5'b00100, 11'd2});                // J over one word
        emit(i2(5'b11000, 4, 8'h32));
        stu(4);
        emit(i2(5'b11000, 4, 8'h21));
        emit({5'b00110, 11'd2});                // JAL
        emit(i2(5'b11000, 4, 8'h22));
        stu(4);
        stu(7);
        for (int k = 0; k < 2; k++) begin      // JR, then JALR with offset 4
            t = (ptr + 5) * 2 - 4 * k;
            emit(i2(5'b11000, 5, 8'(t >> 8)));
            emit(i2(5'b10010, 5, 8'(t)));
            emit(i2(5'b11000, 4, 8'(65 + 16 * k)));
            emit(i2(k == 0 ? 5'b00101 : 5'b00111, 5, 8'(4 * k)));
            emit(i2(5'b11000, 4, 8'(66 + 16 * k)));
            stu(4);
        end
        stu(7);
        emit(16'h0000);                         // HALT
        mPc = '0;
        for (int r = 0; r < `REG_CNT; r++) mReg[r] = '0;
        steps = 0;
        do steps++; while (!isaStep() && steps < 5000);
        limit = 8 + steps + 40;
        t = expAddr.size();
        firstWord = imem[0];
        imem[0] = i1(5'b10000, 0, 0, 5'd0);     // ST sits at PC 0 for the first half of reset
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            checkBit("reset dmemWe", 1'b0, dmemWe);
            checkBit("reset dmemRe", 1'b0, dmemRe);
            checkBit("reset halted", 1'b0, halted);
            if (k == 3) imem[0] = i1(5'b10001, 0, 1, 5'd0);   // Then an LD
        end
        imem[0] = firstWord;
        rstN = 1'b1;
        #1 checkAddr("reset pc", 16'h0000, imemAddr);
        endTest("reset");
        while (!halted && cycles < limit) @(negedge clk);
        if (!halted) begin
            $display("Timeout: the core never halted within %0d cycles", limit);
            failCnt++;
        end else begin
            repeat (5) @(negedge clk);          // No stores may follow HALT
            checkBit("halt level", 1'b1, halted);
            checkAddr("halt pc", mPc, imemAddr);
            checkWord("store count", 16'(t), 16'(stores));
            checkWord("load count", 16'(mLoads), 16'(loads));
            endTest("halt");
        end
        $display("%0d passed, %0d failed", passCnt, failCnt);
        if (failCnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: wiscCore.sv
// Single-cycle core top level with register select, write-back mux and write gating
`include "wisc_defs.svh"

module wiscCore (
    input  logic          clk,
    input  logic          rstN,
    output wiscPkg::addrT imemAddr,
    input  wiscPkg::wordT imemData,
    output wiscPkg::addrT dmemAddr,
    output wiscPkg::wordT dmemWdata,
    output logic          dmemWe,
    output logic          dmemRe,
    input  wiscPkg::wordT dmemRdata,
    output logic          halted
);

    wiscPkg::ctrlT    ctrl;
    wiscPkg::regAddrT rsAddr, rtAddr, wrAddr;
    wiscPkg::wordT    rsData, rtData, imm, aluB, aluRes, wbData;
    wiscPkg::addrT    pc, pcPlus2;
    logic             rsZero, rsNeg, wrEn;

    assign rsAddr = imemData[`RS_HI:`RS_LO];
    assign rtAddr = imemData[`RT_HI:`RT_LO];    // Rt, or store source Rd
    assign rsZero = (rsData == '0);
    assign rsNeg  = rsData[`WORD_W-1];

    always_comb begin
        case (ctrl.linkSel)
            wiscPkg::linkRs:  wrAddr = rsAddr;      // LBI, SLBI, STU
            wiscPkg::linkRdI: wrAddr = rtAddr;
            wiscPkg::linkR7:  wrAddr = wiscPkg::regAddrT'(`REG_CNT - 1);
            default:          wrAddr = imemData[`RD_HI:`RD_LO];
        endcase
    end

    assign aluB   = ctrl.immExt ? imm : rtData;
    assign wbData = ctrl.pc2Reg ? pcPlus2 : (ctrl.val2Reg ? dmemRdata : aluRes);

    // No side effects once stopped or in reset
    assign wrEn   = ctrl.regWrite & ~halted & rstN;
    assign dmemWe = ctrl.memWrite & ~halted & rstN;
    assign dmemRe = ctrl.memRead & ~halted & rstN;

    assign imemAddr  = pc;
    assign dmemAddr  = aluRes;
    assign dmemWdata = rtData;

    control uCtrl (.instr(imemData), .rsZero(rsZero), .rsNeg(rsNeg), .ctrl(ctrl));

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .rdAddr1(rsAddr), .rdAddr2(rtAddr),
        .rdData1(rsData), .rdData2(rtData),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wbData)
    );

    alu uAlu (.aluOp(ctrl.aluOp), .a(rsData), .b(aluB), .result(aluRes));

    immExtend uImm (.instr(imemData), .immSel(ctrl.immSel), .imm(imm));

    pcUnit uPc (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .rsData(rsData), .imm(imm),
        .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
    );

endmodule

// File: wiscPkg.sv
// Shared vector typedefs, ALU and selector codes, and the decoder control struct
`include "wisc_defs.svh"

package wiscPkg;

    typedef logic [`WORD_W-1:0] wordT;      // Data word
    typedef logic [`WORD_W-1:0] addrT;      // Byte address, PC and data memory
    typedef logic [`REG_AW-1:0] regAddrT;   // Register number
    typedef logic [`OPC_W-1:0]  opcodeT;    // Major opcode

    // Low two bits of the first eight codes line up with the opcode/func bits
    typedef enum logic [`ALUOP_W-1:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,    // b - a, as the ISA defines SUB
        aluXor   = 4'd2,
        aluAndn  = 4'd3,
        aluRol   = 4'd4,
        aluSll   = 4'd5,
        aluRor   = 4'd6,
        aluSrl   = 4'd7,
        aluSeq   = 4'd8,
        aluSlt   = 4'd9,
        aluSle   = 4'd10,
        aluSco   = 4'd11,
        aluBtr   = 4'd12,
        aluPassB = 4'd13,   // LBI
        aluSlbi  = 4'd14
    } aluOpT;

    typedef enum logic [2:0] {
        immZero5, immSign5, immZero8, immSign8, immSign11
    } immSelT;

    typedef enum logic [1:0] {
        linkRs,             // Bits 10:8
        linkRdI,            // Bits 7:5
        linkR7,             // JAL, JALR
        linkRdR             // Bits 4:2
    } linkSelT;

    typedef struct packed {
        logic    regWrite;
        logic    pcSel;     // Branch or jump taken
        logic    jumpReg;   // Target base is Rs, not PC+2
        logic    pc2Reg;    // Write back PC+2
        logic    memRead;
        logic    memWrite;
        logic    val2Reg;   // Write back load data
        logic    immExt;    // ALU B is the immediate
        immSelT  immSel;
        linkSelT linkSel;
        aluOpT   aluOp;
        logic    halt;
    } ctrlT;

endpackage

// File: wisc_defs.svh
// Width macros, instruction field positions, immediate field widths and the halt opcode
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

`define WORD_W   16         // Data and byte address width
`define REG_CNT  8          // Architectural registers R0..R7
`define REG_AW   3          // Register number width
`define OPC_W    5          // Major opcode width
`define ALUOP_W  4          // ALU operation code width

`define OPC_HI   15         // Opcode field
`define OPC_LO   11
`define RS_HI    10         // Rs field, all formats
`define RS_LO    8
`define RT_HI    7          // Rt for R-format, Rd for I-format 1
`define RT_LO    5
`define RD_HI    4          // Rd for R-format
`define RD_LO    2

`define IMM5_W   5          // I-format 1 immediate
`define IMM8_W   8          // I-format 2 immediate
`define IMM11_W  11         // J-format displacement

`define HALT_OPC 5'b00000

`endif
